/* rtl/rocache_pkg.sv */
`default_nettype none

package rocache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_LINES     = 8;                         // total lines held by the cache.
    localparam int ASSOCIATIVITY = 2;                         // ways per set, power of two.
    localparam int NUM_SETS      = NUM_LINES / ASSOCIATIVITY; // sets addressed by the index.

    ////////////////////////////////////////////////////////////////////////////
    // address fields and bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_BITS   = 32;                    // byte address width of both buses.
    localparam int ADR_BITS    = ADDR_BITS;             // wishbone adr field width.
    localparam int LINE_BITS   = 256;                   // one line is one bus data word.
    localparam int SEL_BITS    = LINE_BITS / 8;         // one select bit per byte lane.
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8); // byte offset inside a line.
    localparam int INDEX_BITS  = $clog2(NUM_SETS);      // selects the set.
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS; // rest of the address.
    localparam int WAY_BITS    = $clog2(ASSOCIATIVITY); // width of a way number.

    ////////////////////////////////////////////////////////////////////////////
    // wishbone classic signal bundles
    ////////////////////////////////////////////////////////////////////////////

    // master to slave direction of one bus.
    typedef struct packed {
        logic                 cyc;   // bus cycle in progress.
        logic                 stb;   // valid transfer on this cycle.
        logic                 we;    // write enable, always low from this cache.
        logic [ADR_BITS-1:0]  adr;   // byte address.
        logic [SEL_BITS-1:0]  sel;   // byte lane selects.
        logic [LINE_BITS-1:0] dat_m; // write data from the master.
    } wb_req_t;

    // slave to master direction of one bus.
    typedef struct packed {
        logic                 ack;   // transfer done, dat_s is valid.
        logic                 rty;   // transfer refused, master may retry later.
        logic [LINE_BITS-1:0] dat_s; // read data from the slave.
    } wb_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,        // waiting for a cpu request.
        LOOKUP,      // registered tags are compared, hit or miss decided.
        FILL,        // memory cycle running for the missing line.
        REFILL_WAIT  // one cycle so the new line can be read back.
    } cache_state_e;

endpackage : rocache_pkg

`default_nettype wire

/* rtl/cache_plru.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_plru (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [rocache_pkg::INDEX_BITS-1:0]  index,       // set being looked up or filled.
    input  logic                                touch,       // record a use of touched_way.
    input  logic [rocache_pkg::WAY_BITS-1:0]    touched_way, // way that was just used.
    output logic [rocache_pkg::WAY_BITS-1:0]    victim       // way to replace in this set.
);

    // tree nodes are stored heap style, node n has children 2n+1 and 2n+2.
    // a node bit names the subtree that was used least recently.
    logic [rocache_pkg::NUM_SETS-1:0][rocache_pkg::ASSOCIATIVITY-2:0] tree_q;
    logic [rocache_pkg::ASSOCIATIVITY-2:0] tree_next; // bits of the indexed set after a touch.

    // walk from the root following the node bits down to a leaf.
    always_comb begin : victim_walk
        int node;
        node   = 0;
        victim = '0;
        for (int lvl = 0; lvl < rocache_pkg::WAY_BITS; lvl++) begin
            victim[rocache_pkg::WAY_BITS-1-lvl] = tree_q[index][node];
            node = 2 * node + 1 + int'(tree_q[index][node]);
        end
    end

    // on the path to the used way, every node is turned to point the other way.
    always_comb begin : touch_walk
        int node;
        node      = 0;
        tree_next = tree_q[index];
        for (int lvl = 0; lvl < rocache_pkg::WAY_BITS; lvl++) begin
            tree_next[node] = ~touched_way[rocache_pkg::WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(touched_way[rocache_pkg::WAY_BITS-1-lvl]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0; // every set starts with way 0 as the victim.
        end else if (touch) begin
            tree_q[index] <= tree_next; // only the addressed set changes.
        end
    end

endmodule : cache_plru

`default_nettype wire

/* rtl/readonly_cache_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module readonly_cache_datapath (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [rocache_pkg::ADR_BITS-1:0]      cpu_adr,   // held stable for the whole request.
    input  logic [rocache_pkg::LINE_BITS-1:0]     mem_dat,   // line returned by memory.
    input  logic [rocache_pkg::WAY_BITS-1:0]      way_sel,   // way to fill or to touch.
    input  logic                                  load_line, // fill way_sel on this edge.
    input  logic                                  touch,     // mark way_sel most recently used.
    output logic [rocache_pkg::ASSOCIATIVITY-1:0] hit,       // one bit per way, registered.
    output logic [rocache_pkg::WAY_BITS-1:0]      victim,    // lru way for the current index.
    output logic [rocache_pkg::LINE_BITS-1:0]     cpu_dat,   // line of the hitting way.
    output logic [rocache_pkg::ADR_BITS-1:0]      mem_adr    // line aligned fill address.
);

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    logic [rocache_pkg::TAG_BITS-1:0]   req_tag;   // tag part of the cpu address.
    logic [rocache_pkg::INDEX_BITS-1:0] req_index; // set selected by the cpu address.

    assign req_tag   = cpu_adr[rocache_pkg::ADDR_BITS-1 -: rocache_pkg::TAG_BITS];
    assign req_index = cpu_adr[rocache_pkg::OFFSET_BITS +: rocache_pkg::INDEX_BITS];

    // memory always gets the start of the line, the offset is dropped.
    assign mem_adr = {cpu_adr[rocache_pkg::ADR_BITS-1:rocache_pkg::OFFSET_BITS],
                      {rocache_pkg::OFFSET_BITS{1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // storage arrays
    ////////////////////////////////////////////////////////////////////////////

    logic [rocache_pkg::TAG_BITS-1:0]  tag_mem  [rocache_pkg::ASSOCIATIVITY][rocache_pkg::NUM_SETS];
    logic [rocache_pkg::LINE_BITS-1:0] data_mem [rocache_pkg::ASSOCIATIVITY][rocache_pkg::NUM_SETS];
    logic [rocache_pkg::ASSOCIATIVITY-1:0][rocache_pkg::NUM_SETS-1:0] valid_q; // per way and set.

    // tag and data are written together when a fill completes.
    always_ff @(posedge clk) begin
        if (load_line) begin
            tag_mem[way_sel][req_index]  <= req_tag; // the tag of the address being served.
            data_mem[way_sel][req_index] <= mem_dat; // the whole line from memory.
        end
    end

    // valid bits start clear so that nothing hits after reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (load_line) begin
            valid_q[way_sel][req_index] <= 1'b1; // line becomes usable from the next read.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // synchronous read and tag compare
    ////////////////////////////////////////////////////////////////////////////

    logic [rocache_pkg::LINE_BITS-1:0]     rd_data [rocache_pkg::ASSOCIATIVITY]; // read lines.
    logic [rocache_pkg::ASSOCIATIVITY-1:0] hit_q;  // compare result, one cycle after the address.

    // every way of the indexed set is read on each edge.
    always_ff @(posedge clk) begin
        for (int w = 0; w < rocache_pkg::ASSOCIATIVITY; w++) begin
            rd_data[w] <= data_mem[w][req_index];
        end
    end

    // a way hits when its line is valid and the stored tag equals the request tag.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q <= '0;
        end else begin
            for (int w = 0; w < rocache_pkg::ASSOCIATIVITY; w++) begin
                hit_q[w] <= valid_q[w][req_index] && (tag_mem[w][req_index] == req_tag);
            end
        end
    end

    assign hit = hit_q; // the controller decides on the same registered vector.

    // at most one way can hit, so the mux simply follows the hit bits.
    always_comb begin
        cpu_dat = '0;
        for (int w = 0; w < rocache_pkg::ASSOCIATIVITY; w++) begin
            if (hit_q[w]) begin
                cpu_dat = rd_data[w];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // replacement state
    ////////////////////////////////////////////////////////////////////////////

    cache_plru u_plru (
        .clk         (clk),
        .arst_n      (arst_n),
        .index       (req_index),
        .touch       (touch),
        .touched_way (way_sel),
        .victim      (victim)
    );

endmodule : readonly_cache_datapath

`default_nettype wire

/* rtl/readonly_cache_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module readonly_cache_controller (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  cpu_cyc,          // cpu bus cycle active.
    input  logic                                  cpu_stb,          // cpu request valid.
    input  logic [rocache_pkg::ASSOCIATIVITY-1:0] hit,              // registered hit vector.
    input  logic [rocache_pkg::WAY_BITS-1:0]      victim,           // lru way of the set.
    input  logic                                  mem_ack,          // fill line delivered.
    input  logic                                  mem_rty,          // fill refused by memory.
    output logic [rocache_pkg::WAY_BITS-1:0]      way_sel,          // way to touch or fill.
    output logic                                  load_line,        // store the memory line.
    output logic                                  touch,            // update the lru bits.
    output logic                                  cpu_ack,          // reply to the cpu.
    output logic                                  cpu_rty,          // retry passed to the cpu.
    output logic                                  mem_cyc,          // memory cycle request.
    output logic                                  mem_stb,          // memory strobe.
    output logic                                  debug_cache_hit,  // lookup found the line.
    output logic                                  debug_cache_miss  // lookup missed.
);

    ////////////////////////////////////////////////////////////////////////////
    // state and captured control
    ////////////////////////////////////////////////////////////////////////////

    rocache_pkg::cache_state_e state_q;  // current state.
    rocache_pkg::cache_state_e state_d;  // state for the next edge.
    logic [rocache_pkg::WAY_BITS-1:0] victim_q; // way picked at the miss, kept for the fill.
    logic                             rty_q;    // the last fill ended with a retry.
    logic                             any_hit;  // some way of the set holds the line.
    logic [rocache_pkg::WAY_BITS-1:0] hit_way;  // number of the hitting way.

    assign any_hit = |hit;

    // hit is one-hot or zero, so the encode just takes the set bit.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < rocache_pkg::ASSOCIATIVITY; w++) begin
            if (hit[w]) begin
                hit_way = rocache_pkg::WAY_BITS'(w);
            end
        end
    end

    // next state.
    always_comb begin
        state_d = state_q;
        case (state_q)
            rocache_pkg::IDLE: begin
                if (cpu_cyc && cpu_stb) begin
                    state_d = rocache_pkg::LOOKUP; // arrays are read on this edge.
                end
            end
            rocache_pkg::LOOKUP: begin
                state_d = any_hit ? rocache_pkg::IDLE : rocache_pkg::FILL;
            end
            rocache_pkg::FILL: begin
                if (mem_ack || mem_rty) begin
                    state_d = rocache_pkg::REFILL_WAIT; // wait states just keep us here.
                end
            end
            rocache_pkg::REFILL_WAIT: begin
                state_d = rty_q ? rocache_pkg::IDLE : rocache_pkg::LOOKUP;
            end
            default: begin
                state_d = rocache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= rocache_pkg::IDLE;
            victim_q <= '0;
            rty_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == rocache_pkg::LOOKUP && !any_hit) begin
                victim_q <= victim; // replacement choice is frozen at the miss.
            end
            if (state_q == rocache_pkg::FILL) begin
                rty_q <= mem_rty; // value on the closing edge of the fill is what stays.
            end else if (state_q != rocache_pkg::REFILL_WAIT) begin
                rty_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    assign load_line = (state_q == rocache_pkg::FILL) && mem_ack; // never on a retry.
    assign way_sel   = (state_q == rocache_pkg::LOOKUP) ? hit_way : victim_q;
    assign touch     = ((state_q == rocache_pkg::LOOKUP) && any_hit) || load_line;

    assign cpu_ack = (state_q == rocache_pkg::LOOKUP) && any_hit;
    assign cpu_rty = (state_q == rocache_pkg::REFILL_WAIT) && rty_q;

    assign mem_cyc = (state_q == rocache_pkg::FILL); // one classic cycle per fill.
    assign mem_stb = (state_q == rocache_pkg::FILL);

    assign debug_cache_hit  = (state_q == rocache_pkg::LOOKUP) && any_hit;
    assign debug_cache_miss = (state_q == rocache_pkg::LOOKUP) && !any_hit;

endmodule : readonly_cache_controller

`default_nettype wire

/* rtl/readonly_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module readonly_cache (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rocache_pkg::wb_req_t cpu_req,          // cpu side bus, cache is the slave.
    output rocache_pkg::wb_rsp_t cpu_rsp,
    output rocache_pkg::wb_req_t mem_req,          // memory side bus, cache is the master.
    input  rocache_pkg::wb_rsp_t mem_rsp,
    output logic                 debug_cache_hit,  // one pulse per lookup that hit.
    output logic                 debug_cache_miss  // one pulse per lookup that missed.
);

    ////////////////////////////////////////////////////////////////////////////
    // datapath and controller handshake
    ////////////////////////////////////////////////////////////////////////////

    logic [rocache_pkg::WAY_BITS-1:0]      way_sel;   // way that is touched or filled.
    logic                                  load_line; // write the fetched line into way_sel.
    logic                                  touch;     // update the replacement bits.
    logic [rocache_pkg::ASSOCIATIVITY-1:0] hit;       // registered per way hit vector.
    logic [rocache_pkg::WAY_BITS-1:0]      victim;    // lru way of the addressed set.

    readonly_cache_datapath u_datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_adr   (cpu_req.adr),
        .mem_dat   (mem_rsp.dat_s),
        .way_sel   (way_sel),
        .load_line (load_line),
        .touch     (touch),
        .hit       (hit),
        .victim    (victim),
        .cpu_dat   (cpu_rsp.dat_s),
        .mem_adr   (mem_req.adr)
    );

    readonly_cache_controller u_controller (
        .clk              (clk),
        .arst_n           (arst_n),
        .cpu_cyc          (cpu_req.cyc),
        .cpu_stb          (cpu_req.stb),
        .hit              (hit),
        .victim           (victim),
        .mem_ack          (mem_rsp.ack),
        .mem_rty          (mem_rsp.rty),
        .way_sel          (way_sel),
        .load_line        (load_line),
        .touch            (touch),
        .cpu_ack          (cpu_rsp.ack),
        .cpu_rty          (cpu_rsp.rty),
        .mem_cyc          (mem_req.cyc),
        .mem_stb          (mem_req.stb),
        .debug_cache_hit  (debug_cache_hit),
        .debug_cache_miss (debug_cache_miss)
    );

    // the cache only reads whole lines, so the rest of the memory request is fixed.
    assign mem_req.we    = 1'b0; // no writes are ever issued.
    assign mem_req.sel   = '1;   // every byte lane of the line is wanted.
    assign mem_req.dat_m = '0;   // write data is unused on a read.

endmodule : readonly_cache

`default_nettype wire

/* sim/wb_line_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_line_memory (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rocache_pkg::wb_req_t req,         // fill request from the cache.
    output rocache_pkg::wb_rsp_t rsp,         // registered reply.
    input  logic [3:0]           wait_cycles, // idle cycles before each reply.
    input  logic                 retry_en,    // refuse cycles aimed at retry_adr.
    input  logic [31:0]          retry_adr    // line address that gets rty.
);

    int                                fill_count; // acked cycles, read by the testbench.
    logic [rocache_pkg::ADR_BITS-1:0]  last_adr;   // adr of the last acked cycle.
    logic [rocache_pkg::SEL_BITS-1:0]  last_sel;   // sel of the last acked cycle.
    logic [3:0]                        wait_cnt;   // wait states spent on this cycle.
    logic                              ack_q;
    logic                              rty_q;
    logic [rocache_pkg::LINE_BITS-1:0] dat_q;

    // every 32-bit word holds the address it was asked for xor its word number.
    function automatic logic [rocache_pkg::LINE_BITS-1:0] build_line(input logic [31:0] adr);
        logic [rocache_pkg::LINE_BITS-1:0] line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = adr ^ 32'(w);
        end
        return line;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q      <= 1'b0;
            rty_q      <= 1'b0;
            dat_q      <= '0;
            wait_cnt   <= '0;
            fill_count <= 0;
            last_adr   <= '0;
            last_sel   <= '0;
        end else begin
            ack_q <= 1'b0; // replies are single cycle pulses.
            rty_q <= 1'b0;
            if (req.cyc && req.stb && !ack_q && !rty_q) begin
                if (wait_cnt < wait_cycles) begin
                    wait_cnt <= wait_cnt + 4'd1; // still inserting wait states.
                end else if (retry_en && req.adr == retry_adr) begin
                    wait_cnt <= '0;
                    rty_q    <= 1'b1; // refused, nothing is counted.
                end else begin
                    wait_cnt   <= '0;
                    ack_q      <= 1'b1;
                    dat_q      <= build_line(req.adr); // taken as given, not realigned.
                    fill_count <= fill_count + 1;
                    last_adr   <= req.adr;
                    last_sel   <= req.sel;
                end
            end
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.rty   = rty_q;
    assign rsp.dat_s = dat_q;

endmodule : wb_line_memory

`default_nettype wire

/* sim/tb_readonly_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_readonly_cache;

    localparam int CYCLE_LIMIT = 4000; // 100 reads at about 30 cycles each and some margin.

    logic                 clk;
    logic                 arst_n;
    rocache_pkg::wb_req_t cpu_req;
    rocache_pkg::wb_rsp_t cpu_rsp;
    rocache_pkg::wb_req_t mem_req;
    rocache_pkg::wb_rsp_t mem_rsp;
    logic                 debug_cache_hit;
    logic                 debug_cache_miss;
    logic [3:0]           wait_cycles;
    logic                 retry_en;
    logic [31:0]          retry_adr;
    int                   errors      = 0; // failed checks.
    int                   reads       = 0; // cpu reads issued.
    int                   cycle_count = 0;

    // reference model of the two-way sets with tags, valid bits and the lru way.
    logic [rocache_pkg::TAG_BITS-1:0] model_tag   [rocache_pkg::NUM_SETS][2];
    logic                             model_valid [rocache_pkg::NUM_SETS][2];
    int                               model_lru   [rocache_pkg::NUM_SETS];

    readonly_cache u_readonly_cache (
        .clk (clk), .arst_n (arst_n), .cpu_req (cpu_req), .cpu_rsp (cpu_rsp),
        .mem_req (mem_req), .mem_rsp (mem_rsp),
        .debug_cache_hit (debug_cache_hit), .debug_cache_miss (debug_cache_miss)
    );

    wb_line_memory u_mem (
        .clk (clk), .arst_n (arst_n), .req (mem_req), .rsp (mem_rsp),
        .wait_cycles (wait_cycles), .retry_en (retry_en), .retry_adr (retry_adr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    // the run is stopped if the DUT stops replying.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles, controller in %s", cycle_count,
                     u_readonly_cache.u_controller.state_q.name());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic flag_mismatch(input string what);
        errors++;
        $display("mismatch at %0t: %s", $time, what);
    endtask

    // the expected line is built from the word rule of the memory.
    function automatic logic [255:0] expected_line(input logic [31:0] line_adr);
        logic [255:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = line_adr ^ w;
        end
        return line;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // one cpu read, checked against the model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_read(input logic [31:0] adr, output logic seen_hit);
        logic [31:0]  line_adr;
        logic [24:0]  tag;
        int           set;
        int           way;
        logic         exp_hit;
        logic         exp_rty;
        int           edges;
        int           hit_pulses;
        int           miss_pulses;
        int           fills_before;
        logic         got_ack;
        logic         got_rty;
        logic [255:0] got_data;
        logic         bad_mem_req;
        line_adr = {adr[31:5], 5'b0};
        tag      = adr[31:7];
        set      = int'(adr[6:5]);
        way      = model_lru[set];
        exp_hit  = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) begin
                exp_hit = 1'b1;
                way     = w;
            end
        end
        exp_rty      = !exp_hit && retry_en && (retry_adr == line_adr);
        fills_before = u_mem.fill_count;
        edges        = 0;
        hit_pulses   = 0;
        miss_pulses  = 0;
        got_ack      = 1'b0;
        got_rty      = 1'b0;
        bad_mem_req  = 1'b0;
        reads++;
        cpu_req.adr = adr; // called on a falling edge, so this is the drive point.
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        while (!got_ack && !got_rty) begin
            @(negedge clk);
            edges++;
            hit_pulses  += int'(debug_cache_hit);
            miss_pulses += int'(debug_cache_miss);
            got_ack  = cpu_rsp.ack;
            got_rty  = cpu_rsp.rty;
            got_data = cpu_rsp.dat_s;
            if (mem_req.we !== 1'b0 || mem_req.dat_m !== '0) begin
                bad_mem_req = 1'b1; // the cache only ever reads from memory.
            end
        end
        @(negedge clk); // the reply is taken on the rising edge in between.
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
        seen_hit = got_ack && (miss_pulses == 0);
        if (exp_rty && (!got_rty || got_ack)) begin
            flag_mismatch($sformatf("adr %h wanted rty, got ack %0b rty %0b", adr, got_ack,
                                    got_rty));
        end
        if (!exp_rty && (!got_ack || got_rty)) begin
            flag_mismatch($sformatf("adr %h wanted ack, got ack %0b rty %0b", adr, got_ack,
                                    got_rty));
        end
        if (got_ack && got_data !== expected_line(line_adr)) begin
            flag_mismatch($sformatf("adr %h data %h", adr, got_data));
        end
        if (seen_hit !== exp_hit) begin
            flag_mismatch($sformatf("adr %h hit %0b, model says %0b", adr, seen_hit, exp_hit));
        end
        if (hit_pulses != (exp_rty ? 0 : 1) || miss_pulses != (exp_hit ? 0 : 1)) begin
            flag_mismatch($sformatf("adr %h debug pulses hit %0d miss %0d", adr, hit_pulses,
                                    miss_pulses));
        end
        if (u_mem.fill_count != fills_before + ((exp_hit || exp_rty) ? 0 : 1)) begin
            flag_mismatch($sformatf("adr %h fill count %0d, was %0d", adr, u_mem.fill_count,
                                    fills_before));
        end
        if (!exp_hit && !exp_rty && (u_mem.last_adr !== line_adr || u_mem.last_sel !== '1)) begin
            flag_mismatch($sformatf("adr %h memory saw adr %h sel %h", adr, u_mem.last_adr,
                                    u_mem.last_sel));
        end
        if (bad_mem_req) begin
            flag_mismatch($sformatf("adr %h memory request had we or write data set", adr));
        end
        // ack seen after the first falling edge is taken on rising edge edges + 1.
        if (exp_hit && edges + 1 != 2) begin
            flag_mismatch($sformatf("adr %h hit ack on edge %0d, not 2", adr, edges + 1));
        end
        if (exp_hit) begin
            model_lru[set] = 1 - way; // the other way is now least recently used.
        end else if (!exp_rty) begin
            model_tag[set][model_lru[set]]   = tag;
            model_valid[set][model_lru[set]] = 1'b1;
            model_lru[set]                   = 1 - model_lru[set];
        end
    endtask

    task automatic expect_outcome(input string label, input logic seen, input logic want);
        if (seen !== want) begin
            flag_mismatch($sformatf("%s: hit %0b, wanted %0b", label, seen, want));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic cold_miss_test();
        logic h;
        check_read(32'h0000_1234, h); // odd offset so memory must see the aligned line.
        expect_outcome("cold read", h, 1'b0);
    endtask

    task automatic hit_test();
        logic h;
        check_read(32'h0000_1238, h); // same line at another offset.
        expect_outcome("repeat read", h, 1'b1);
    endtask

    task automatic replacement_test();
        logic h;
        check_read(32'h0001_0040, h); // a, b and c all land in set 2.
        expect_outcome("first a", h, 1'b0);
        check_read(32'h0002_0040, h);
        expect_outcome("first b", h, 1'b0);
        check_read(32'h0001_0044, h);
        expect_outcome("second a", h, 1'b1);
        check_read(32'h0003_0040, h); // b is lru and goes.
        expect_outcome("first c", h, 1'b0);
        check_read(32'h0001_0048, h);
        expect_outcome("third a", h, 1'b1);
        check_read(32'h0002_0040, h);
        expect_outcome("b after eviction", h, 1'b0);
    endtask

    task automatic retry_test();
        logic h;
        retry_adr = 32'h0000_2060;
        retry_en  = 1'b1;
        check_read(32'h0000_2064, h); // model predicts the rty.
        retry_en = 1'b0;
        check_read(32'h0000_2064, h);
        expect_outcome("read after retry", h, 1'b0); // nothing was filled before.
    endtask

    task automatic random_test();
        logic        h;
        logic [3:0]  n;
        logic [31:0] adr;
        for (int i = 0; i < 80; i++) begin
            n           = 4'($urandom % 16);
            wait_cycles = 4'($urandom % 8);
            adr         = 32'h0004_0000 + (32'(n[3:2]) << 12) + (32'(n[1:0]) << 5);
            adr         = adr + ($urandom % 32); // any byte of the line.
            check_read(adr, h);
        end
    endtask

    initial begin : main
        void'($urandom(32'h9a34_9704));
        cpu_req     = '0;
        wait_cycles = 4'd0;
        retry_en    = 1'b0;
        retry_adr   = '0;
        arst_n      = 1'b0;
        for (int s = 0; s < rocache_pkg::NUM_SETS; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_tag[s][0]   = '0;
            model_tag[s][1]   = '0;
            model_lru[s]      = 0; // way 0 is the first victim after reset.
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        if (cpu_rsp.ack || cpu_rsp.rty || mem_req.cyc || mem_req.stb ||
            debug_cache_hit || debug_cache_miss) begin
            flag_mismatch("bus control or debug output high after reset");
        end
        cold_miss_test();
        hit_test();
        replacement_test();
        retry_test();
        random_test();
        $display("reads: %0d, errors: %0d", reads, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_readonly_cache

`default_nettype wire

/* vlog.f */
rtl/rocache_pkg.sv
rtl/cache_plru.sv
rtl/readonly_cache_datapath.sv
rtl/readonly_cache_controller.sv
rtl/readonly_cache.sv
sim/wb_line_memory.sv
sim/tb_readonly_cache.sv

/* run_sim.sh */
#!/bin/sh
# build the cache testbench with verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    --top-module tb_readonly_cache -o tb_readonly_cache -f vlog.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_readonly_cache > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log

grep -q "^STATUS: PASS$" sim.log && exit 0 || exit 1
